// File: tb.f
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/retire_stage.sv
hdl/pipe_core.sv
bench/retire_checker.sv
bench/tb_top.sv

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam logic [31:0] RESET_ADDR = 32'h0;
  localparam int          N_INIT     = 7;   // x1..x7 get values first
  localparam int          N_RANDOM   = 24;
  localparam int          N_CHAIN    = 12;
  localparam int          N_X0       = 8;
  localparam int          N_ILLEGAL  = 4;
  localparam int          PROG_LEN   = N_INIT + N_RANDOM + N_CHAIN + N_X0 + N_ILLEGAL + 1;
  localparam int          TIMEOUT    = 2 * PROG_LEN + 40;  // every word may stall once
  localparam logic [31:0] LFSR_SEED  = 32'd38;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [6:0]  OPC_IMM    = 7'b0010011;
  localparam logic [6:0]  OPC_LUI    = 7'b0110111;

  logic        clk;
  logic        rst;
  logic [31:0] imem_rdata;
  logic [31:0] imem_raddr;
  logic        retire_valid;
  logic [31:0] retire_inst;
  logic        retire_trap;
  logic        retire_halt;
  logic [4:0]  retire_rs1_raddr;
  logic [4:0]  retire_rs2_raddr;
  logic [31:0] retire_rs1_rdata;
  logic [31:0] retire_rs2_rdata;
  logic [4:0]  retire_rd_waddr;
  logic [31:0] retire_rd_wdata;
  logic [31:0] retire_pc;
  logic [31:0] retire_next_pc;
  logic        done;
  logic [31:0] checked;
  logic [31:0] errors;
  logic [31:0] imem [0:PROG_LEN-1];
  logic [31:0] lfsr_state;
  int          n_words;
  int          cycle_cnt = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst        = 1'b1;
    imem_rdata = 32'h0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;  // four edges seen in reset
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit handed out and the newest bit lands at the bottom
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = 32'h0;
    for (int k = 0; k < n; k++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [2:0] r;
    r = take_bits(3);
    return {2'b00, r};  // x0..x7 keeps dependencies frequent
  endfunction

  // legal op or op-imm word with the given registers
  function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    logic        use_reg;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    use_reg = take_bits(1);
    f3      = take_bits(3);
    alt     = take_bits(1);
    imm     = take_bits(12);
    if (use_reg) begin
      return {1'b0, alt && ((f3 == 3'b000) || (f3 == 3'b101)), 5'b0, rs2, rs1, f3, rd, OPC_OP};
    end
    if ((f3 == 3'b001) || (f3 == 3'b101)) begin  // shifts keep funct7 legal
      return {1'b0, alt && (f3 == 3'b101), 5'b0, imm[4:0], rs1, f3, rd, OPC_IMM};
    end
    return {imm, rs1, f3, rd, OPC_IMM};
  endfunction

  task automatic add_word(input logic [31:0] w, input logic [2:0] sec);
    imem[n_words] = w;
    u_checker.store_word(n_words, w, sec);
    n_words++;
  endtask

  initial begin : build_program
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev_rd;
    logic [19:0] imm20;
    logic [11:0] imm12;
    logic [1:0]  sel;
    logic [24:0] upper;
    logic [6:0]  opc;
    lfsr_state = LFSR_SEED;
    n_words    = 0;
    for (rd = 5'd1; rd <= 5'd7; rd = rd + 5'd1) begin
      imm20 = take_bits(20);
      imm12 = take_bits(12);
      if (rd < 5'd5) add_word({imm20, rd, OPC_LUI}, 3'd0);
      else add_word({imm12, 5'd0, 3'b000, rd, OPC_IMM}, 3'd0);  // addi from x0
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      add_word(rand_alu(rd, rs1, rs2), 3'd1);
    end
    prev_rd = 5'd1;
    for (int k = 0; k < N_CHAIN; k++) begin
      rd = pick_reg();
      if (rd == 5'd0) rd = 5'd1;  // the chain needs a real destination
      rs2 = pick_reg();
      add_word(rand_alu(rd, prev_rd, rs2), 3'd2);
      prev_rd = rd;
    end
    for (int k = 0; k < N_X0; k++) begin
      rd    = 5'd0;
      rs1   = pick_reg();
      rs2   = pick_reg();
      imm20 = take_bits(20);
      if (k != 0) rd = pick_reg();
      if (k % 2 == 0) add_word({imm20, rd, OPC_LUI}, 3'd3);
      else add_word(rand_alu(5'd0, rs1, rs2), 3'd3);
    end
    for (int k = 0; k < N_ILLEGAL; k++) begin
      sel   = take_bits(2);
      upper = take_bits(25);
      case (sel)
        2'd0:    opc = 7'b0000011;  // load
        2'd1:    opc = 7'b0100011;  // store
        2'd2:    opc = 7'b1100011;  // branch
        default: opc = 7'b1110011;  // system word other than ebreak
      endcase
      add_word({upper, opc}, 3'd4);
    end
    add_word(32'h0010_0073, 3'd5);
  end

  function automatic logic [31:0] imem_read(input logic [31:0] addr);
    logic [31:0] widx;
    widx = (addr - RESET_ADDR) >> 2;
    if (widx < PROG_LEN) return imem[widx];
    return addr ^ 32'h2aaa_aaab;  // words past the program are built from the whole address
  endfunction

  // the word for the sampled address follows the edge as in a synchronous memory
  always @(posedge clk) imem_rdata <= imem_read(imem_raddr);

  pipe_core #(.RESET_ADDR(RESET_ADDR)) UUT (
    .i_clk              (clk),
    .i_rst              (rst),
    .i_imem_rdata       (imem_rdata),
    .o_imem_raddr       (imem_raddr),
    .o_retire_valid     (retire_valid),
    .o_retire_inst      (retire_inst),
    .o_retire_trap      (retire_trap),
    .o_retire_halt      (retire_halt),
    .o_retire_rs1_raddr (retire_rs1_raddr),
    .o_retire_rs2_raddr (retire_rs2_raddr),
    .o_retire_rs1_rdata (retire_rs1_rdata),
    .o_retire_rs2_rdata (retire_rs2_rdata),
    .o_retire_rd_waddr  (retire_rd_waddr),
    .o_retire_rd_wdata  (retire_rd_wdata),
    .o_retire_pc        (retire_pc),
    .o_retire_next_pc   (retire_next_pc)
  );

  retire_checker #(.PROG_LEN(PROG_LEN), .RESET_ADDR(RESET_ADDR)) u_checker (
    .i_clk              (clk),
    .i_rst              (rst),
    .i_retire_valid     (retire_valid),
    .i_retire_inst      (retire_inst),
    .i_retire_trap      (retire_trap),
    .i_retire_halt      (retire_halt),
    .i_retire_rs1_raddr (retire_rs1_raddr),
    .i_retire_rs2_raddr (retire_rs2_raddr),
    .i_retire_rs1_rdata (retire_rs1_rdata),
    .i_retire_rs2_rdata (retire_rs2_rdata),
    .i_retire_rd_waddr  (retire_rd_waddr),
    .i_retire_rd_wdata  (retire_rd_wdata),
    .i_retire_pc        (retire_pc),
    .i_retire_next_pc   (retire_next_pc),
    .o_done             (done),
    .o_checked          (checked),
    .o_errors           (errors)
  );

  initial begin : run_ctrl
    @(posedge clk);
    while ((done !== 1'b1) && (cycle_cnt < TIMEOUT)) @(posedge clk);
    if (done !== 1'b1) begin
      $display("timeout: ebreak did not retire within %0d cycles", TIMEOUT);
    end
    $display("totals: %0d instructions checked, %0d errors", checked, errors);
    if ((done === 1'b1) && (errors == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: bench/retire_checker.sv
`timescale 1ns/1ps

module retire_checker #(
  parameter int          PROG_LEN   = 16,
  parameter logic [31:0] RESET_ADDR = 32'h0
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_retire_valid,
  input  logic [31:0] i_retire_inst,
  input  logic        i_retire_trap,
  input  logic        i_retire_halt,
  input  logic [4:0]  i_retire_rs1_raddr,
  input  logic [4:0]  i_retire_rs2_raddr,
  input  logic [31:0] i_retire_rs1_rdata,
  input  logic [31:0] i_retire_rs2_rdata,
  input  logic [4:0]  i_retire_rd_waddr,
  input  logic [31:0] i_retire_rd_wdata,
  input  logic [31:0] i_retire_pc,
  input  logic [31:0] i_retire_next_pc,
  output logic        o_done,
  output logic [31:0] o_checked,
  output logic [31:0] o_errors
);

  localparam logic [6:0]  OPC_OP     = 7'b0110011;
  localparam logic [6:0]  OPC_IMM    = 7'b0010011;
  localparam logic [6:0]  OPC_LUI    = 7'b0110111;
  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  localparam logic [31:0] EBREAK     = 32'h0010_0073;

  logic [31:0] prog   [0:PROG_LEN-1];  // copy of what the memory model holds
  logic [2:0]  sec_of [0:PROG_LEN-1];  // which test each word belongs to
  logic [31:0] model  [0:31];          // architectural registers where x0 stays zero
  logic [31:0] exp_pc;
  int          idx;                    // program index of the next expected retire
  int          checked;
  int          errors;
  int          sec_checks;
  int          sec_errors;

  assign o_checked = checked;
  assign o_errors  = errors;

  initial begin
    for (int r = 0; r < 32; r++) begin
      model[r] = 32'h0;
    end
    exp_pc     = RESET_ADDR;  // first retire must come from the reset address
    idx        = 0;
    checked    = 0;
    errors     = 0;
    sec_checks = 0;
    sec_errors = 0;
    o_done     = 1'b0;
  end

  // called by the program builder for every word it places in memory
  task automatic store_word(input int i, input logic [31:0] w, input logic [2:0] sec);
    prog[i]   = w;
    sec_of[i] = sec;
  endtask

  function automatic string sec_name(input logic [2:0] s);
    case (s)
      3'd0:    return "reset and register init";
      3'd1:    return "random alu";
      3'd2:    return "dependent chain";
      3'd3:    return "lui and x0 writes";
      3'd4:    return "illegal opcodes";
      default: return "ebreak halt";
    endcase
  endfunction

  // {rs1, rs2} as the isa says the word reads them
  function automatic logic [9:0] src_regs(input logic [31:0] inst);
    if (inst[6:0] == OPC_OP) return {inst[19:15], inst[24:20]};
    if (inst[6:0] == OPC_IMM) return {inst[19:15], 5'd0};
    return 10'd0;  // lui, ebreak and illegal words read nothing
  endfunction

  // expected {halt, trap, rd, result} from the word and the register model
  function automatic logic [38:0] ref_exec(input logic [31:0] inst);
    logic [6:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    opc = inst[6:0];
    a   = model[inst[19:15]];
    b   = (opc == OPC_OP) ? model[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    res = 32'h0;
    if (opc == OPC_LUI) return {2'b00, inst[11:7], inst[31:12], 12'h000};
    if (inst == EBREAK) return {2'b10, 5'd0, 32'h0};
    if ((opc != OPC_OP) && (opc != OPC_IMM)) return {2'b01, 5'd0, 32'h0};  // trap and no register write
    case (inst[14:12])
      3'b000: res = ((opc == OPC_OP) && inst[30]) ? a - b : a + b;  // sub only in the reg form
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (inst[30]) res = $signed(a) >>> b[4:0];  // sign fills from the top
        else res = a >> b[4:0];
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return {2'b00, inst[11:7], res};
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("[FAIL] %s at pc 0x%08h: expected 0x%08h, got 0x%08h", name, exp_pc, exp, got);
      errors++;
      sec_errors++;
    end
  endtask

  // retire outputs settle after the edge, so the next edge samples them clean
  always @(posedge i_clk) begin : compare
    logic [31:0] inst;
    logic [38:0] exp;
    logic [9:0]  srcs;
    if (i_rst) begin
      if (i_retire_valid === 1'b1) begin
        $display("retire valid went high while reset was asserted");
        errors++;
      end
    end else if (!o_done && (i_retire_valid === 1'b1)) begin
      if (idx >= PROG_LEN) begin
        $display("an instruction retired past the end of the program");
        errors++;
        o_done <= 1'b1;
      end else begin
        inst = prog[idx];
        srcs = src_regs(inst);
        exp  = ref_exec(inst);
        check_field("o_retire_pc", exp_pc, i_retire_pc);
        check_field("o_retire_next_pc", exp_pc + 32'd4, i_retire_next_pc);
        check_field("o_retire_inst", inst, i_retire_inst);  // catches reorder or repeats
        check_field("o_retire_rs1_raddr", srcs[9:5], i_retire_rs1_raddr);
        check_field("o_retire_rs2_raddr", srcs[4:0], i_retire_rs2_raddr);
        check_field("o_retire_rs1_rdata", model[srcs[9:5]], i_retire_rs1_rdata);
        check_field("o_retire_rs2_rdata", model[srcs[4:0]], i_retire_rs2_rdata);
        check_field("o_retire_rd_waddr", exp[36:32], i_retire_rd_waddr);
        check_field("o_retire_trap", exp[37], i_retire_trap);
        check_field("o_retire_halt", exp[38], i_retire_halt);
        if (exp[36:32] != 5'd0) begin
          check_field("o_retire_rd_wdata", exp[31:0], i_retire_rd_wdata);
          model[exp[36:32]] = exp[31:0];  // x0 is never written in the model
        end
        checked++;
        sec_checks++;
        if ((idx == PROG_LEN - 1) || (sec_of[idx+1] != sec_of[idx])) begin
          $display("%s: %0d retired, %0d errors", sec_name(sec_of[idx]), sec_checks, sec_errors);
          sec_checks = 0;
          sec_errors = 0;
        end
        if (exp[38] || (i_retire_halt === 1'b1)) begin
          o_done <= 1'b1;  // ebreak ends the program
        end
        exp_pc = exp_pc + 32'd4;
        idx++;
      end
    end
  end

endmodule

// File: hdl/pipe_core.sv
`timescale 1ns/1ps

module pipe_core import core_pkg::*; #(
  parameter word_t RESET_ADDR = '0  // handed down to fetch
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  word_t     i_imem_rdata,
  output word_t     o_imem_raddr,
  output logic      o_retire_valid,
  output word_t     o_retire_inst,
  output logic      o_retire_trap,
  output logic      o_retire_halt,
  output reg_addr_t o_retire_rs1_raddr,
  output reg_addr_t o_retire_rs2_raddr,
  output word_t     o_retire_rs1_rdata,
  output word_t     o_retire_rs2_rdata,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc
);

  logic      stall;
  logic      dec_valid;
  word_t     dec_inst;
  word_t     dec_pc;
  logic      ex_valid;
  word_t     ex_inst;
  word_t     ex_pc;
  alu_op_e   ex_alu_op;
  word_t     ex_op_a;
  word_t     ex_op_b;
  reg_addr_t ex_rd;
  word_t     ex_rs1_rdata;
  word_t     ex_rs2_rdata;
  logic      ex_trap;
  logic      ex_halt;
  logic      wb_valid;
  word_t     wb_inst;
  word_t     wb_pc;
  reg_addr_t wb_rd;
  word_t     wb_result;
  word_t     wb_rs1_rdata;
  word_t     wb_rs2_rdata;
  logic      wb_trap;
  logic      wb_halt;
  logic      rd_wen;      // writeback request looping back into decode
  reg_addr_t rd_waddr;
  word_t     rd_wdata;

  fetch_unit #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_stall      (stall),
    .i_imem_rdata (i_imem_rdata),
    .o_imem_raddr (o_imem_raddr),
    .o_dec_valid  (dec_valid),
    .o_dec_inst   (dec_inst),
    .o_dec_pc     (dec_pc)
  );

  decode_stage u_decode (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_dec_valid    (dec_valid),
    .i_dec_inst     (dec_inst),
    .i_dec_pc       (dec_pc),
    .i_rd_wen       (rd_wen),
    .i_rd_waddr     (rd_waddr),
    .i_rd_wdata     (rd_wdata),
    .o_stall        (stall),
    .o_ex_valid     (ex_valid),
    .o_ex_inst      (ex_inst),
    .o_ex_pc        (ex_pc),
    .o_ex_alu_op    (ex_alu_op),
    .o_ex_op_a      (ex_op_a),
    .o_ex_op_b      (ex_op_b),
    .o_ex_rd        (ex_rd),
    .o_ex_rs1_rdata (ex_rs1_rdata),
    .o_ex_rs2_rdata (ex_rs2_rdata),
    .o_ex_trap      (ex_trap),
    .o_ex_halt      (ex_halt)
  );

  execute_stage u_execute (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_ex_valid     (ex_valid),
    .i_ex_inst      (ex_inst),
    .i_ex_pc        (ex_pc),
    .i_ex_alu_op    (ex_alu_op),
    .i_ex_op_a      (ex_op_a),
    .i_ex_op_b      (ex_op_b),
    .i_ex_rd        (ex_rd),
    .i_ex_rs1_rdata (ex_rs1_rdata),
    .i_ex_rs2_rdata (ex_rs2_rdata),
    .i_ex_trap      (ex_trap),
    .i_ex_halt      (ex_halt),
    .o_wb_valid     (wb_valid),
    .o_wb_inst      (wb_inst),
    .o_wb_pc        (wb_pc),
    .o_wb_rd        (wb_rd),
    .o_wb_result    (wb_result),
    .o_wb_rs1_rdata (wb_rs1_rdata),
    .o_wb_rs2_rdata (wb_rs2_rdata),
    .o_wb_trap      (wb_trap),
    .o_wb_halt      (wb_halt)
  );

  retire_stage u_retire (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_wb_valid         (wb_valid),
    .i_wb_inst          (wb_inst),
    .i_wb_pc            (wb_pc),
    .i_wb_rd            (wb_rd),
    .i_wb_result        (wb_result),
    .i_wb_rs1_rdata     (wb_rs1_rdata),
    .i_wb_rs2_rdata     (wb_rs2_rdata),
    .i_wb_trap          (wb_trap),
    .i_wb_halt          (wb_halt),
    .o_rd_wen           (rd_wen),
    .o_rd_waddr         (rd_waddr),
    .o_rd_wdata         (rd_wdata),
    .o_retire_valid     (o_retire_valid),
    .o_retire_inst      (o_retire_inst),
    .o_retire_trap      (o_retire_trap),
    .o_retire_halt      (o_retire_halt),
    .o_retire_rs1_raddr (o_retire_rs1_raddr),
    .o_retire_rs2_raddr (o_retire_rs2_raddr),
    .o_retire_rs1_rdata (o_retire_rs1_rdata),
    .o_retire_rs2_rdata (o_retire_rs2_rdata),
    .o_retire_rd_waddr  (o_retire_rd_waddr),
    .o_retire_rd_wdata  (o_retire_rd_wdata),
    .o_retire_pc        (o_retire_pc),
    .o_retire_next_pc   (o_retire_next_pc)
  );

endmodule

// File: hdl/retire_stage.sv
`timescale 1ns/1ps

module retire_stage import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_wb_valid,
  input  word_t     i_wb_inst,
  input  word_t     i_wb_pc,
  input  reg_addr_t i_wb_rd,
  input  word_t     i_wb_result,
  input  word_t     i_wb_rs1_rdata,
  input  word_t     i_wb_rs2_rdata,
  input  logic      i_wb_trap,
  input  logic      i_wb_halt,
  output logic      o_rd_wen,
  output reg_addr_t o_rd_waddr,
  output word_t     o_rd_wdata,
  output logic      o_retire_valid,
  output word_t     o_retire_inst,
  output logic      o_retire_trap,
  output logic      o_retire_halt,
  output reg_addr_t o_retire_rs1_raddr,
  output reg_addr_t o_retire_rs2_raddr,
  output word_t     o_retire_rs1_rdata,
  output word_t     o_retire_rs2_rdata,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc
);

  logic [6:0] opcode;
  logic       reads_rs1;
  logic       reads_rs2;

  assign opcode    = i_wb_inst[6:0];
  assign reads_rs1 = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);  // same rule as decode
  assign reads_rs2 = (opcode == OPC_OP);

  // rd is already zero for traps, halts, bubbles and x0 targets
  assign o_rd_wen   = i_wb_valid && (i_wb_rd != '0);
  assign o_rd_waddr = i_wb_rd;
  assign o_rd_wdata = i_wb_result;

  assign o_retire_valid     = i_wb_valid;
  assign o_retire_inst      = i_wb_inst;
  assign o_retire_trap      = i_wb_trap;
  assign o_retire_halt      = i_wb_halt;
  assign o_retire_rs1_raddr = reads_rs1 ? i_wb_inst[19:15] : '0;
  assign o_retire_rs2_raddr = reads_rs2 ? i_wb_inst[24:20] : '0;
  assign o_retire_rs1_rdata = i_wb_rs1_rdata;  // zero whenever the address is
  assign o_retire_rs2_rdata = i_wb_rs2_rdata;
  assign o_retire_rd_waddr  = i_wb_rd;
  assign o_retire_rd_wdata  = i_wb_result;
  assign o_retire_pc        = i_wb_pc;
  assign o_retire_next_pc   = i_wb_pc + word_t'(4);  // nothing redirects fetch

  // decode flags ebreak only on a legal system word, never as illegal too
  a_halt_trap_excl: assert property (@(posedge i_clk) disable iff (i_rst)
    i_wb_valid |-> !(i_wb_halt && i_wb_trap));

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_ex_valid,
  input  word_t     i_ex_inst,
  input  word_t     i_ex_pc,
  input  alu_op_e   i_ex_alu_op,
  input  word_t     i_ex_op_a,
  input  word_t     i_ex_op_b,
  input  reg_addr_t i_ex_rd,
  input  word_t     i_ex_rs1_rdata,
  input  word_t     i_ex_rs2_rdata,
  input  logic      i_ex_trap,
  input  logic      i_ex_halt,
  output logic      o_wb_valid,
  output word_t     o_wb_inst,
  output word_t     o_wb_pc,
  output reg_addr_t o_wb_rd,
  output word_t     o_wb_result,
  output word_t     o_wb_rs1_rdata,
  output word_t     o_wb_rs2_rdata,
  output logic      o_wb_trap,
  output logic      o_wb_halt
);

  logic [4:0] shamt;
  word_t      result;

  assign shamt = i_ex_op_b[4:0];  // upper bits of the shift operand are ignored

  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD:    result = i_ex_op_a + i_ex_op_b;
      ALU_SUB:    result = i_ex_op_a - i_ex_op_b;
      ALU_SLL:    result = i_ex_op_a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(i_ex_op_a) < $signed(i_ex_op_b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, i_ex_op_a < i_ex_op_b};
      ALU_XOR:    result = i_ex_op_a ^ i_ex_op_b;
      ALU_SRL:    result = i_ex_op_a >> shamt;
      ALU_SRA:    result = word_t'($signed(i_ex_op_a) >>> shamt);  // sign fills from the top
      ALU_OR:     result = i_ex_op_a | i_ex_op_b;
      ALU_AND:    result = i_ex_op_a & i_ex_op_b;
      ALU_PASS_B: result = i_ex_op_b;  // lui
      default:    result = '0;
    endcase
  end

  // execute to writeback register
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_valid <= 1'b0;
      o_wb_rd    <= '0;
      o_wb_trap  <= 1'b0;
      o_wb_halt  <= 1'b0;
    end else begin
      o_wb_valid <= i_ex_valid;
      o_wb_rd    <= i_ex_rd;
      o_wb_trap  <= i_ex_trap;
      o_wb_halt  <= i_ex_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb_inst      <= i_ex_inst;
    o_wb_pc        <= i_ex_pc;
    o_wb_result    <= result;
    o_wb_rs1_rdata <= i_ex_rs1_rdata;
    o_wb_rs2_rdata <= i_ex_rs2_rdata;
  end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_dec_valid,
  input  word_t     i_dec_inst,
  input  word_t     i_dec_pc,
  input  logic      i_rd_wen,        // write port from retire
  input  reg_addr_t i_rd_waddr,
  input  word_t     i_rd_wdata,
  output logic      o_stall,         // back to fetch, holds the decode register
  output logic      o_ex_valid,
  output word_t     o_ex_inst,
  output word_t     o_ex_pc,
  output alu_op_e   o_ex_alu_op,
  output word_t     o_ex_op_a,
  output word_t     o_ex_op_b,
  output reg_addr_t o_ex_rd,
  output word_t     o_ex_rs1_rdata,
  output word_t     o_ex_rs2_rdata,
  output logic      o_ex_trap,
  output logic      o_ex_halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_op;
  logic       is_op_imm;
  logic       is_lui;
  logic       is_halt;
  logic       is_trap;
  reg_addr_t  rs1_raddr;
  reg_addr_t  rs2_raddr;
  reg_addr_t  rd_eff;
  word_t      rs1_rdata;
  word_t      rs2_rdata;
  word_t      imm_i;
  word_t      imm_u;
  alu_op_e    alu_op;

  assign opcode    = i_dec_inst[6:0];
  assign funct3    = i_dec_inst[14:12];
  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);
  assign is_lui    = (opcode == OPC_LUI);
  assign is_halt   = (opcode == OPC_SYSTEM) && (i_dec_inst[31:7] == INST_EBREAK[31:7]);
  assign is_trap   = !(is_op || is_op_imm || is_lui || is_halt);  // illegal word

  // unused source fields read as x0, which keeps hazards and retire honest
  assign rs1_raddr = (is_op || is_op_imm) ? i_dec_inst[19:15] : '0;
  assign rs2_raddr = is_op ? i_dec_inst[24:20] : '0;
  assign rd_eff    = (is_op || is_op_imm || is_lui) ? i_dec_inst[11:7] : '0;

  assign imm_i = {{(XLEN-12){i_dec_inst[31]}}, i_dec_inst[31:20]};
  assign imm_u = {i_dec_inst[31:12], 12'b0};

  always_comb begin
    alu_op = ALU_ADD;  // traps and halts do not care
    if (is_lui) begin
      alu_op = ALU_PASS_B;
    end else begin
      case (funct3)
        F3_ADD_SUB: alu_op = (is_op && i_dec_inst[30]) ? ALU_SUB : ALU_ADD;  // no subi
        F3_SLL:     alu_op = ALU_SLL;
        F3_SLT:     alu_op = ALU_SLT;
        F3_SLTU:    alu_op = ALU_SLTU;
        F3_XOR:     alu_op = ALU_XOR;
        F3_SRL_SRA: alu_op = i_dec_inst[30] ? ALU_SRA : ALU_SRL;  // same bit for srai
        F3_OR:      alu_op = ALU_OR;
        F3_AND:     alu_op = ALU_AND;
        default:    alu_op = ALU_ADD;
      endcase
    end
  end

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (rs1_raddr),
    .i_rs2_raddr (rs2_raddr),
    .i_rd_wen    (i_rd_wen),
    .i_rd_waddr  (i_rd_waddr),
    .i_rd_wdata  (i_rd_wdata),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata)
  );

  hazard_unit u_hazard_unit (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_dec_valid (i_dec_valid),
    .i_dec_rs1   (rs1_raddr),
    .i_dec_rs2   (rs2_raddr),
    .i_ex_valid  (o_ex_valid),
    .i_ex_rd     (o_ex_rd),
    .o_stall     (o_stall)
  );

  // a stall turns this slot into a bubble, the instruction waits in decode
  always_ff @(posedge i_clk) begin
    if (i_rst || o_stall) begin
      o_ex_valid <= 1'b0;
      o_ex_rd    <= '0;
      o_ex_trap  <= 1'b0;
      o_ex_halt  <= 1'b0;
    end else begin
      o_ex_valid <= i_dec_valid;
      o_ex_rd    <= i_dec_valid ? rd_eff : '0;  // hazard unit relies on this zero
      o_ex_trap  <= i_dec_valid && is_trap;
      o_ex_halt  <= i_dec_valid && is_halt;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex_inst      <= o_stall ? INST_NOP : i_dec_inst;
    o_ex_pc        <= i_dec_pc;
    o_ex_alu_op    <= alu_op;
    o_ex_op_a      <= rs1_rdata;
    o_ex_op_b      <= is_op ? rs2_rdata : (is_lui ? imm_u : imm_i);
    o_ex_rs1_rdata <= rs1_rdata;  // kept apart from op_a for the retire port
    o_ex_rs2_rdata <= rs2_rdata;
  end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_dec_valid,
  input  reg_addr_t i_dec_rs1,    // zero when the instruction has no rs1
  input  reg_addr_t i_dec_rs2,    // zero when the instruction has no rs2
  input  logic      i_ex_valid,
  input  reg_addr_t i_ex_rd,      // zero for anything that writes no register
  output logic      o_stall
);

  logic rs1_hit;
  logic rs2_hit;

  // x0 never makes a dependency, which also covers unused source fields
  assign rs1_hit = (i_dec_rs1 != '0) && (i_dec_rs1 == i_ex_rd);
  assign rs2_hit = (i_dec_rs2 != '0) && (i_dec_rs2 == i_ex_rd);

  // only execute needs checking, writeback is bypassed in the register file
  assign o_stall = i_dec_valid && i_ex_valid && (rs1_hit || rs2_hit);

  // a stall keeps the instruction in decode and puts a bubble into execute,
  // so the next cycle it must still be there and proceed without stalling
  a_stall_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
    o_stall |=> (i_dec_valid && !o_stall));

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_raddr,
  input  reg_addr_t i_rs2_raddr,
  input  logic      i_rd_wen,
  input  reg_addr_t i_rd_waddr,
  input  word_t     i_rd_wdata,
  output word_t     o_rs1_rdata,
  output word_t     o_rs2_rdata
);

  word_t regs [1:31];  // x0 has no storage at all

  // a write in the same cycle wins over the stored value, so decode never
  // has to wait on an instruction that is already in writeback
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) return '0;
    if (i_rd_wen && (i_rd_waddr == addr)) return i_rd_wdata;
    return regs[addr];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rd_wen && (i_rd_waddr != '0)) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  always_comb begin
    o_rs1_rdata = read_port(i_rs1_raddr);
    o_rs2_rdata = read_port(i_rs2_raddr);
  end

  // retire only asks for a write when rd is a real register
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rd_wen |-> (i_rd_waddr != '0));

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
  parameter word_t RESET_ADDR = '0  // first fetch address, must be word aligned
) (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_stall,       // hold decode and replay the current fetch
  input  word_t i_imem_rdata,  // word for the address sampled at the last edge
  output word_t o_imem_raddr,
  output logic  o_dec_valid,
  output word_t o_dec_inst,
  output word_t o_dec_pc
);

  word_t pc_q;        // address handed to the memory when not stalled
  word_t rd_pc_q;     // address of the word sitting on i_imem_rdata
  logic  rd_valid_q;  // i_imem_rdata is a real fetch and not reset leftovers

  // on a stall the memory gets the address of the word it is returning now,
  // so the same word is still there when decode finally takes it
  assign o_imem_raddr = i_stall ? rd_pc_q : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q       <= RESET_ADDR;
      rd_pc_q    <= RESET_ADDR;
      rd_valid_q <= 1'b0;  // the first word out of reset is not yet back
    end else if (!i_stall) begin
      pc_q       <= pc_q + word_t'(4);  // no jumps, so always the next word
      rd_pc_q    <= pc_q;
      rd_valid_q <= 1'b1;
    end
  end

  // fetch to decode register, valid is the only control bit in it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_dec_valid <= 1'b0;
    end else if (!i_stall) begin
      o_dec_valid <= rd_valid_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_dec_inst <= i_imem_rdata;
      o_dec_pc   <= rd_pc_q;  // pc travels with its word
    end
  end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

  localparam int XLEN = 32;  // data and address width of the core

  typedef logic [XLEN-1:0] word_t;  // one data word or byte address
  typedef logic [4:0]      reg_addr_t;  // architectural register index

  // major opcodes this core executes, anything else retires as a trap
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // register-register alu
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // register-immediate alu
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // only ebreak is accepted here

  // funct3 encodings shared by the OP and OP_IMM groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;  // bit 30 of the word picks sra
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // operations the execute stage knows about
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui just forwards the u-type immediate
  } alu_op_e;

  localparam word_t INST_EBREAK = 32'h0010_0073;  // halts the test program
  localparam word_t INST_NOP    = 32'h0000_0013;  // addi x0, x0, 0 fills bubbles

endpackage
